/* all.f */
verilog/eth_tx_pkg.sv
verilog/slot_pkg.sv
verilog/slot_writer.sv
verilog/slot_ram.sv
verilog/fcs_gen.sv
verilog/timed_sender.sv
verilog/tx_sched_top.sv
testbench/tx_sched_checker.sv
testbench/tb_tx_sched.sv

/* testbench/tb_tx_sched.sv */
`timescale 1ns/10ps

module tb_tx_sched;

  localparam logic [31:0] seed = 32'h4e4;
  localparam int len_imm = 60;
  localparam int len_odd = 61;
  localparam int len_b2b0 = 40;
  localparam int len_b2b1 = 52;
  localparam int len_b2b2 = 33;
  localparam int len_park = 60;
  // takes every word left beside the parked frame
  localparam int len_fill = 2 * (slot_pkg::depth - 2 * eth_tx_pkg::hdr_words - len_park / 2);
  localparam int len_late = 45;
  localparam int sched_delay = 200;
  localparam int park_delay = 3000;
  localparam int idle_hold = 100;
  localparam int total_bytes = 2 * len_imm + len_odd + len_b2b0 + len_b2b1 + len_b2b2
                             + len_park + len_fill + len_late;
  localparam int frame_extra = eth_tx_pkg::preamble_len + 4 + eth_tx_pkg::ifg_cycles + 6;
  localparam int cycle_limit = 4 * (total_bytes + 9 * frame_extra + sched_delay + park_delay
                                    + idle_hold + 16);

  logic                             gmii_tx_clk;
  logic                             sys_rst;
  slot_pkg::wb_req_t                wb_req;
  slot_pkg::wb_rsp_t                wb_rsp;
  logic [eth_tx_pkg::time_bits-1:0] global_time;
  eth_tx_pkg::gmii_t                gmii;
  logic [31:0]                      rng;
  int                               cycle;
  logic [7:0]                       payload[$];
  eth_tx_pkg::gmii_t                captured[$];
  logic [eth_tx_pkg::time_bits-1:0] first_time;
  int                               first_cycle;
  int                               last_cycle;
  int                               ack_cycle;

  tx_sched_top u_dut (
    .gmii_tx_clk (gmii_tx_clk),
    .sys_rst     (sys_rst),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .global_time (global_time),
    .gmii        (gmii)
  );

  always #2 gmii_tx_clk = ~gmii_tx_clk;

  always @(posedge gmii_tx_clk) cycle <= cycle + 1;

  always @(negedge gmii_tx_clk) global_time <= global_time + 1'b1;

  always @(negedge gmii_tx_clk) begin
    if (cycle >= cycle_limit) report_failure("timeout, the tests did not finish in time");
    if (u_dut.u_checker.fail_cnt != 0) report_failure("a bound assertion on the DUT failed");
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic compare_gmii(input string what, input eth_tx_pkg::gmii_t got,
                              input eth_tx_pkg::gmii_t exp);
    if (got !== exp) report_failure($sformatf("Mismatch %s: got %h, expected %h", what, got, exp));
  endtask

  task automatic compare_rsp(input string what, input slot_pkg::wb_rsp_t got,
                             input slot_pkg::wb_rsp_t exp);
    if (got !== exp) report_failure($sformatf("Mismatch %s: got %h, expected %h", what, got, exp));
  endtask

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // bitwise reflected crc-32 over the payload
  function automatic logic [31:0] ref_fcs();
    logic [31:0] c;
    logic        fb;
    c = 32'hffffffff;
    foreach (payload[i]) begin
      for (int b = 0; b < 8; b++) begin
        fb = c[0] ^ payload[i][b];
        c = c >> 1;
        if (fb) c = c ^ 32'hedb88320;
      end
    end
    return ~c;
  endfunction

  function automatic eth_tx_pkg::gmii_t lane(input logic [7:0] b);
    eth_tx_pkg::gmii_t g;
    g.en = 1'b1;
    g.data = b;
    return g;
  endfunction

  // high byte first, odd tail padded with zero
  function automatic logic [15:0] payload_word(input int i);
    logic [7:0] lo;
    lo = (2 * i + 1 < payload.size()) ? payload[2 * i + 1] : 8'h00;
    return {payload[2 * i], lo};
  endfunction

  task automatic make_payload(input int len);
    payload.delete();
    repeat (len) begin
      rng = next_rand(rng);
      payload.push_back(rng[31:24]);
    end
  endtask

  task automatic wb_cycle(input slot_pkg::host_op_e op, input logic we,
                          input logic [15:0] dat, output slot_pkg::wb_rsp_t rsp);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we = we;
    wb_req.adr = op;
    wb_req.dat = dat;
    @(negedge gmii_tx_clk);
    while (!wb_rsp.ack) @(negedge gmii_tx_clk);
    rsp = wb_rsp;
    ack_cycle = cycle;
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
  endtask

  task automatic push_word(input logic [15:0] dat);
    slot_pkg::wb_rsp_t rsp;
    wb_cycle(slot_pkg::op_push, 1'b1, dat, rsp);
  endtask

  task automatic commit_frames();
    slot_pkg::wb_rsp_t rsp;
    wb_cycle(slot_pkg::op_commit, 1'b1, '0, rsp);
  endtask

  task automatic read_free(input int words);
    slot_pkg::wb_rsp_t rsp;
    slot_pkg::wb_rsp_t exp;
    wb_cycle(slot_pkg::op_free, 1'b0, '0, rsp);
    exp.ack = 1'b1;
    exp.dat = 16'(words);
    compare_rsp("wb_rsp free words", rsp, exp);
  endtask

  // header then data words, optionally keeping the last word back
  task automatic push_frame(input logic [eth_tx_pkg::time_bits-1:0] launch, input bit hold_last);
    int n_words;
    n_words = (payload.size() + 1) / 2;
    push_word(16'(payload.size()));
    push_word(launch[47:32]);
    push_word(launch[31:16]);
    push_word(launch[15:0]);
    for (int i = 0; i < n_words - hold_last; i++) push_word(payload_word(i));
  endtask

  task automatic capture_frame();
    captured.delete();
    while (!gmii.en) @(negedge gmii_tx_clk);
    first_time = global_time;
    first_cycle = cycle;
    while (gmii.en) begin
      captured.push_back(gmii);
      last_cycle = cycle;
      @(negedge gmii_tx_clk);
    end
  endtask

  task automatic check_frame(input string name);
    eth_tx_pkg::gmii_t exp_q[$];
    logic [31:0]       fcs;
    fcs = ref_fcs();
    repeat (eth_tx_pkg::preamble_len - 1) exp_q.push_back(lane(eth_tx_pkg::preamble_byte));
    exp_q.push_back(lane(eth_tx_pkg::sfd_byte));
    foreach (payload[i]) exp_q.push_back(lane(payload[i]));
    for (int i = 0; i < 4; i++) exp_q.push_back(lane(fcs[8 * i +: 8]));
    if (captured.size() != exp_q.size())
      report_failure($sformatf("%s frame has %0d bytes on GMII, %0d expected",
                               name, captured.size(), exp_q.size()));
    foreach (exp_q[i]) compare_gmii($sformatf("gmii byte %0d of %s", i, name), captured[i], exp_q[i]);
  endtask

  // go needs global_time at the launch time, en follows one edge later
  task automatic check_launch(input logic [eth_tx_pkg::time_bits-1:0] launch);
    if (first_time < launch) report_failure("frame started before its launch time");
    if (first_time > launch + 2) report_failure("frame started late after its launch time");
  endtask

  task automatic test_single_frame(input int len, input string name);
    make_payload(len);
    push_frame('0, 1'b0);
    commit_frames();
    capture_frame();
    check_frame(name);
  endtask

  task automatic test_scheduled();
    logic [eth_tx_pkg::time_bits-1:0] launch;
    launch = global_time + sched_delay;
    make_payload(len_imm);
    push_frame(launch, 1'b0);
    commit_frames();
    capture_frame();
    check_frame("scheduled");
    check_launch(launch);
  endtask

  task automatic test_back_to_back();
    int          lens[3] = '{len_b2b0, len_b2b1, len_b2b2};
    logic [31:0] rng_start;
    int          prev_last;
    rng_start = rng;
    foreach (lens[i]) begin
      make_payload(lens[i]);
      push_frame('0, 1'b0);
    end
    commit_frames();
    // same seed state gives the same payloads again
    rng = rng_start;
    foreach (lens[i]) begin
      make_payload(lens[i]);
      capture_frame();
      check_frame($sformatf("back-to-back frame %0d", i));
      if (i > 0 && first_cycle - prev_last - 1 < eth_tx_pkg::ifg_cycles)
        report_failure("idle gap between back-to-back frames too short");
      prev_last = last_cycle;
    end
  endtask

  task automatic test_uncommitted();
    make_payload(len_late);
    push_frame('0, 1'b0);
    repeat (idle_hold) begin
      @(negedge gmii_tx_clk);
      if (gmii.en) report_failure("GMII transmit started before the commit");
    end
    commit_frames();
    capture_frame();
    check_frame("after commit");
  endtask

  task automatic test_back_pressure();
    logic [eth_tx_pkg::time_bits-1:0] launch;
    logic [31:0]                      rng_park;
    logic [31:0]                      rng_fill;
    logic [15:0]                      last_word;
    launch = global_time + park_delay;
    rng_park = rng;
    make_payload(len_park);
    push_frame(launch, 1'b0);
    commit_frames();
    read_free(slot_pkg::depth - 1 - eth_tx_pkg::hdr_words - len_park / 2);
    rng_fill = rng;
    make_payload(len_fill);
    push_frame('0, 1'b1);
    read_free(0);
    last_word = payload_word(len_fill / 2 - 1);
    // last push stalls until the parked frame frees its words
    fork
      capture_frame();
      push_word(last_word);
    join
    if (ack_cycle <= last_cycle) report_failure("push was accepted while the buffer was full");
    rng = rng_park;
    make_payload(len_park);
    check_frame("parked");
    check_launch(launch);
    commit_frames();
    rng = rng_fill;
    make_payload(len_fill);
    capture_frame();
    check_frame("fill");
  endtask

  initial begin
    gmii_tx_clk = 1'b0;
    sys_rst = 1'b1;
    wb_req = '0;
    global_time = '0;
    cycle = 0;
    rng = seed;
    repeat (16) @(negedge gmii_tx_clk);
    sys_rst = 1'b0;
    test_single_frame(len_imm, "immediate");
    test_single_frame(len_odd, "odd length");
    test_scheduled();
    test_back_to_back();
    test_uncommitted();
    test_back_pressure();
    repeat (20) @(negedge gmii_tx_clk);
    if (u_dut.u_checker.fail_cnt != 0) begin
      report_failure("a bound assertion on the DUT failed");
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

/* testbench/tx_sched_checker.sv */
`timescale 1ns/10ps

module tx_sched_checker (
  input logic                             gmii_tx_clk,
  input logic                             sys_rst,
  input eth_tx_pkg::gmii_t                gmii,
  input slot_pkg::wb_rsp_t                wb_rsp,
  input logic [eth_tx_pkg::time_bits-1:0] global_time,
  input logic [eth_tx_pkg::time_bits-1:0] launch_time
);

  // count of failed assertions
  int fail_cnt = 0;

  // idle gap after every frame
  assert property (@(posedge gmii_tx_clk) disable iff (sys_rst)
    $fell(gmii.en) |-> !gmii.en [*eth_tx_pkg::ifg_cycles])
  else begin
    fail_cnt++;
    $error("inter-frame gap shorter than %0d cycles", eth_tx_pkg::ifg_cycles);
  end

  // en rises one edge after the launch test passed
  assert property (@(posedge gmii_tx_clk) disable iff (sys_rst)
    $rose(gmii.en) |-> ((launch_time == '0) || ($past(global_time) >= launch_time)))
  else begin
    fail_cnt++;
    $error("transmit started before the launch time");
  end

  assert property (@(posedge gmii_tx_clk) disable iff (sys_rst)
    wb_rsp.ack |=> !wb_rsp.ack)
  else begin
    fail_cnt++;
    $error("wishbone ack held for more than one cycle");
  end

endmodule

bind tx_sched_top tx_sched_checker u_checker (
  .gmii_tx_clk (gmii_tx_clk),
  .sys_rst     (sys_rst),
  .gmii        (gmii),
  .wb_rsp      (wb_rsp),
  .global_time (global_time),
  .launch_time (u_sender.launch_time)
);

/* verilog/eth_tx_pkg.sv */
package eth_tx_pkg;

  // frame header in the buffer
  // length, then launch time high, middle, low
  localparam int hdr_words = 4;
  localparam int hdr_cnt_bits = $clog2(hdr_words);
  localparam int len_bits = 16;

  // minimum idle cycles between frames
  localparam int ifg_cycles = 12;
  localparam int ifg_cnt_bits = $clog2(ifg_cycles + 1);

  // preamble and start of frame delimiter
  localparam int preamble_len = 8;
  localparam logic [7:0] preamble_byte = 8'h55;
  localparam logic [7:0] sfd_byte = 8'hd5;

  // byte counter covers preamble plus the largest frame
  localparam int byte_cnt_bits = len_bits + 1;

  // ethernet fcs, reflected crc-32
  localparam int fcs_len = 4;
  localparam int fcs_cnt_bits = $clog2(fcs_len);
  localparam logic [31:0] crc_poly = 32'hedb88320;

  localparam int time_bits = 48;

  typedef enum logic [2:0] {
    idle     = 3'd0,
    mem_wait = 3'd1,
    hdr_load = 3'd2,
    waiting  = 3'd3,
    sending  = 3'd4,
    fcs      = 3'd5
  } tx_state_e;

  // one gmii transmit byte lane
  typedef struct packed {
    logic       en;
    logic [7:0] data;
  } gmii_t;

endpackage

/* verilog/fcs_gen.sv */
`timescale 1ns/10ps

module fcs_gen (
  input  logic        gmii_tx_clk,
  input  logic        sys_rst,
  input  logic        init,
  input  logic        data_en,
  input  logic [7:0]  data,
  output logic [31:0] crc
);

  logic [31:0] crc_q;

  // one byte through the reflected crc-32, lsb first
  function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
    logic [31:0] r;
    r = c ^ {24'h0, d};
    for (int i = 0; i < 8; i++) begin
      if (r[0]) begin
        r = (r >> 1) ^ eth_tx_pkg::crc_poly;
      end else begin
        r = r >> 1;
      end
    end
    return r;
  endfunction

  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst || init) begin
      crc_q <= '1;
    end else if (data_en) begin
      crc_q <= crc_byte(crc_q, data);
    end
  end

  // complemented, byte 0 goes out first
  assign crc = ~crc_q;

endmodule

/* verilog/slot_pkg.sv */
package slot_pkg;

  // ring buffer of 16-bit words
  localparam int addr_bits = 10;
  localparam int word_bits = 16;
  localparam int depth = 1 << addr_bits;

  // host register map on the wishbone address
  typedef enum logic [1:0] {
    op_push   = 2'd0,
    op_commit = 2'd1,
    op_free   = 2'd2
  } host_op_e;

  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    host_op_e             adr;
    logic [word_bits-1:0] dat;
  } wb_req_t;

  // dat carries the free word count
  typedef struct packed {
    logic                 ack;
    logic [word_bits-1:0] dat;
  } wb_rsp_t;

endpackage

/* verilog/slot_ram.sv */
`timescale 1ns/10ps

module slot_ram (
  input  logic                           gmii_tx_clk,
  input  logic                           we,
  input  logic [slot_pkg::addr_bits-1:0] waddr,
  input  logic [slot_pkg::word_bits-1:0] wdata,
  input  logic [slot_pkg::addr_bits-1:0] raddr,
  output logic [slot_pkg::word_bits-1:0] rdata
);

  logic [slot_pkg::word_bits-1:0] mem [slot_pkg::depth];

  always_ff @(posedge gmii_tx_clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // registered read, data one cycle after raddr
  always_ff @(posedge gmii_tx_clk) begin
    rdata <= mem[raddr];
  end

endmodule

/* verilog/slot_writer.sv */
`timescale 1ns/10ps

module slot_writer (
  input  logic                           gmii_tx_clk,
  input  logic                           sys_rst,
  input  slot_pkg::wb_req_t              wb_req,
  output slot_pkg::wb_rsp_t              wb_rsp,
  input  logic [slot_pkg::addr_bits-1:0] rd_ptr,
  output logic [slot_pkg::addr_bits-1:0] wr_ptr,
  output logic                           ram_we,
  output logic [slot_pkg::addr_bits-1:0] ram_waddr,
  output logic [slot_pkg::word_bits-1:0] ram_wdata
);

  // words land at stage_ptr, the sender only sees wr_ptr
  logic [slot_pkg::addr_bits-1:0] stage_ptr;
  logic [slot_pkg::addr_bits-1:0] free_cnt;
  logic [slot_pkg::word_bits-1:0] rsp_dat;
  logic                           ack;
  logic                           req_new;
  logic                           full;

  // new cycle only while no ack is out
  assign req_new = wb_req.cyc && wb_req.stb && !ack;

  // one slot stays empty so full and empty differ
  assign full = (stage_ptr + 1'b1) == rd_ptr;
  assign free_cnt = rd_ptr - stage_ptr - 1'b1;

  assign wb_rsp.ack = ack;
  assign wb_rsp.dat = rsp_dat;

  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst) begin
      ack       <= 1'b0;
      ram_we    <= 1'b0;
      stage_ptr <= '0;
      wr_ptr    <= '0;
    end else begin
      ack    <= 1'b0;
      ram_we <= 1'b0;
      if (req_new) begin
        case (wb_req.adr)
          slot_pkg::op_push: begin
            if (!wb_req.we) begin
              ack <= 1'b1;
            end else if (!full) begin
              // no ack while full, host keeps stb up
              ack       <= 1'b1;
              ram_we    <= 1'b1;
              stage_ptr <= stage_ptr + 1'b1;
            end
          end
          slot_pkg::op_commit: begin
            ack <= 1'b1;
            if (wb_req.we) begin
              wr_ptr <= stage_ptr;
            end
          end
          slot_pkg::op_free: begin
            ack <= 1'b1;
          end
          default: begin
            ack <= 1'b1;
          end
        endcase
      end
    end
  end

  always_ff @(posedge gmii_tx_clk) begin
    if (req_new) begin
      ram_waddr <= stage_ptr;
      ram_wdata <= wb_req.dat;
      rsp_dat   <= {{(slot_pkg::word_bits - slot_pkg::addr_bits){1'b0}}, free_cnt};
    end
  end

endmodule

/* verilog/timed_sender.sv */
`timescale 1ns/10ps

module timed_sender (
  input  logic                             gmii_tx_clk,
  input  logic                             sys_rst,
  input  logic [eth_tx_pkg::time_bits-1:0] global_time,
  input  logic [slot_pkg::addr_bits-1:0]   wr_ptr,
  output logic [slot_pkg::addr_bits-1:0]   rd_ptr,
  output logic [slot_pkg::addr_bits-1:0]   ram_raddr,
  input  logic [slot_pkg::word_bits-1:0]   ram_rdata,
  output eth_tx_pkg::gmii_t                gmii
);

  eth_tx_pkg::tx_state_e state;

  logic [eth_tx_pkg::ifg_cnt_bits-1:0]  gap_cnt;
  logic [eth_tx_pkg::hdr_cnt_bits-1:0]  hdr_cnt;
  logic [eth_tx_pkg::fcs_cnt_bits-1:0]  fcs_cnt;
  logic [eth_tx_pkg::byte_cnt_bits-1:0] byte_cnt;
  logic [eth_tx_pkg::byte_cnt_bits-1:0] data_idx;
  logic [eth_tx_pkg::len_bits-1:0]      tx_len;
  logic [eth_tx_pkg::time_bits-1:0]     launch_time;
  logic [slot_pkg::addr_bits-1:0]       frame_words;
  logic [slot_pkg::addr_bits-1:0]       next_rd_ptr;
  logic [7:0]                           hold_lo;
  logic [7:0]                           tx_byte;
  logic [7:0]                           gmii_data;
  logic [31:0]                          crc;
  logic                                 gmii_en;
  logic                                 gap_done;
  logic                                 launch_ok;
  logic                                 go;
  logic                                 last_byte;
  logic                                 crc_en;
  logic                                 word_fetch;

  assign gap_done = gap_cnt == eth_tx_pkg::ifg_cycles[eth_tx_pkg::ifg_cnt_bits-1:0];

  // zero launch time means send as soon as possible
  // a late frame still goes out
  assign launch_ok = (launch_time == '0) || (global_time >= launch_time);
  assign go = (state == eth_tx_pkg::waiting) && gap_done && launch_ok;

  assign data_idx = byte_cnt - eth_tx_pkg::preamble_len[eth_tx_pkg::byte_cnt_bits-1:0];
  assign last_byte = byte_cnt == {1'b0, tx_len} + eth_tx_pkg::preamble_len - 1;

  // header plus data words rounded up, freed at frame end
  assign frame_words = tx_len[slot_pkg::addr_bits:1] + tx_len[0];
  assign next_rd_ptr = rd_ptr + frame_words
                     + eth_tx_pkg::hdr_words[slot_pkg::addr_bits-1:0];

  // next byte for the lane
  always_comb begin
    tx_byte = eth_tx_pkg::preamble_byte;
    crc_en = 1'b0;
    case (state)
      eth_tx_pkg::sending: begin
        if (byte_cnt == eth_tx_pkg::preamble_len - 1) begin
          tx_byte = eth_tx_pkg::sfd_byte;
        end else if (byte_cnt >= eth_tx_pkg::preamble_len) begin
          crc_en = 1'b1;
          // high byte of each word first
          tx_byte = data_idx[0] ? hold_lo : ram_rdata[slot_pkg::word_bits-1 -: 8];
        end
      end
      eth_tx_pkg::fcs: begin
        tx_byte = crc[8*fcs_cnt +: 8];
      end
      default: begin
        tx_byte = eth_tx_pkg::preamble_byte;
      end
    endcase
  end

  // even data byte takes a fresh word
  assign word_fetch = crc_en && !data_idx[0];

  fcs_gen u_fcs (
    .gmii_tx_clk (gmii_tx_clk),
    .sys_rst     (sys_rst),
    .init        (go),
    .data_en     (crc_en),
    .data        (tx_byte),
    .crc         (crc)
  );

  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst) begin
      state     <= eth_tx_pkg::idle;
      gap_cnt   <= '0;
      hdr_cnt   <= '0;
      fcs_cnt   <= '0;
      byte_cnt  <= '0;
      rd_ptr    <= '0;
      ram_raddr <= '0;
      gmii_en   <= 1'b0;
    end else begin
      gmii_en <= 1'b0;
      if (!gap_done) begin
        gap_cnt <= gap_cnt + 1'b1;
      end
      case (state)
        eth_tx_pkg::idle: begin
          // detect cycle plus mem_wait cover the read latency
          if (wr_ptr != rd_ptr) begin
            ram_raddr <= rd_ptr;
            hdr_cnt   <= '0;
            state     <= eth_tx_pkg::mem_wait;
          end
        end
        eth_tx_pkg::mem_wait: begin
          ram_raddr <= ram_raddr + 1'b1;
          state     <= eth_tx_pkg::hdr_load;
        end
        eth_tx_pkg::hdr_load: begin
          hdr_cnt <= hdr_cnt + 1'b1;
          if (hdr_cnt == eth_tx_pkg::hdr_words - 1) begin
            // address parks on the first data word
            state <= eth_tx_pkg::waiting;
          end else begin
            ram_raddr <= ram_raddr + 1'b1;
          end
        end
        eth_tx_pkg::waiting: begin
          if (go) begin
            byte_cnt <= '0;
            state    <= eth_tx_pkg::sending;
          end
        end
        eth_tx_pkg::sending: begin
          gmii_en  <= 1'b1;
          byte_cnt <= byte_cnt + 1'b1;
          if (word_fetch) begin
            ram_raddr <= ram_raddr + 1'b1;
          end
          if (last_byte) begin
            fcs_cnt <= '0;
            state   <= eth_tx_pkg::fcs;
          end
        end
        eth_tx_pkg::fcs: begin
          gmii_en <= 1'b1;
          fcs_cnt <= fcs_cnt + 1'b1;
          if (fcs_cnt == eth_tx_pkg::fcs_len - 1) begin
            // whole frame released at once
            rd_ptr  <= next_rd_ptr;
            gap_cnt <= '0;
            state   <= eth_tx_pkg::idle;
          end
        end
        default: begin
          state <= eth_tx_pkg::idle;
        end
      endcase
    end
  end

  always_ff @(posedge gmii_tx_clk) begin
    gmii_data <= tx_byte;
    if (state == eth_tx_pkg::hdr_load) begin
      case (hdr_cnt)
        2'd0: tx_len <= ram_rdata;
        2'd1: launch_time[47:32] <= ram_rdata;
        2'd2: launch_time[31:16] <= ram_rdata;
        2'd3: launch_time[15:0] <= ram_rdata;
        default: tx_len <= ram_rdata;
      endcase
    end
    if (word_fetch) begin
      hold_lo <= ram_rdata[7:0];
    end
  end

  assign gmii.en = gmii_en;
  assign gmii.data = gmii_data;

endmodule

/* verilog/tx_sched_top.sv */
`timescale 1ns/10ps

module tx_sched_top (
  input  logic                             gmii_tx_clk,
  input  logic                             sys_rst,
  input  slot_pkg::wb_req_t                wb_req,
  output slot_pkg::wb_rsp_t                wb_rsp,
  input  logic [eth_tx_pkg::time_bits-1:0] global_time,
  output eth_tx_pkg::gmii_t                gmii
);

  logic [slot_pkg::addr_bits-1:0] wr_ptr;
  logic [slot_pkg::addr_bits-1:0] rd_ptr;
  logic                           ram_we;
  logic [slot_pkg::addr_bits-1:0] ram_waddr;
  logic [slot_pkg::word_bits-1:0] ram_wdata;
  logic [slot_pkg::addr_bits-1:0] ram_raddr;
  logic [slot_pkg::word_bits-1:0] ram_rdata;

  slot_writer u_writer (
    .gmii_tx_clk (gmii_tx_clk),
    .sys_rst     (sys_rst),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .rd_ptr      (rd_ptr),
    .wr_ptr      (wr_ptr),
    .ram_we      (ram_we),
    .ram_waddr   (ram_waddr),
    .ram_wdata   (ram_wdata)
  );

  slot_ram u_ram (
    .gmii_tx_clk (gmii_tx_clk),
    .we          (ram_we),
    .waddr       (ram_waddr),
    .wdata       (ram_wdata),
    .raddr       (ram_raddr),
    .rdata       (ram_rdata)
  );

  timed_sender u_sender (
    .gmii_tx_clk (gmii_tx_clk),
    .sys_rst     (sys_rst),
    .global_time (global_time),
    .wr_ptr      (wr_ptr),
    .rd_ptr      (rd_ptr),
    .ram_raddr   (ram_raddr),
    .ram_rdata   (ram_rdata),
    .gmii        (gmii)
  );

endmodule
